//--- list.f
source/quant_pkg.sv
source/out_row_sequencer.sv
source/scale_bank.sv
source/requant_lane.sv
source/requant_top.sv
dv/requant_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := requant_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/requant_tb.sv
`timescale 1ns/1ns
`default_nettype none

module requant_tb;

  import quant_pkg::*;

  ////////////////////////////////////////////////////////////
  // stimulus records
  ////////////////////////////////////////////////////////////

  // one table entry, either a scale load or a drain
  typedef struct packed {
    logic       is_drain;
    logic       mode;
    logic [7:0] start;
    logic [7:0] size;
    // 0 small sums, 1 extremes
    logic [1:0] psum_kind;
    // drain cycle for a second start pulse, 0 for none
    logic [4:0] restart_at;
  } stim_t;

  localparam int num_steps = 10;
  localparam int cycle_limit = 40 * num_steps + 100;
  // last row's last result lands 21 cycles in
  localparam int drain_cycles = 22;

  logic clk = 1'b0;
  logic reset;
  logic scale_load;
  scale_load_t scale_cfg;
  scale_word_u scale_word;
  logic drain_start;
  logic [sa_row_num-1:0] psum_valid;
  row_psum_t psum [sa_row_num];
  logic [sa_row_num-1:0] quant_valid;
  row_quant_t quant [sa_row_num];
  logic drain_done;

  stim_t stim_table [num_steps];
  int seed = 19981;
  int cycle_count = 0;

  // reference copy of the 64 scale sets, index 0 unused
  logic [7:0] model_lo [0:64];
  logic [7:0] model_hi [0:64];

  // partial sums of the current drain, per row and index
  logic signed [psum_width-1:0] p_lo [4][17];
  logic signed [psum_width-1:0] p_hi [4][17];

  requant_top requant_top_i (
    .clk         (clk),
    .reset       (reset),
    .scale_load  (scale_load),
    .scale_cfg   (scale_cfg),
    .scale_word  (scale_word),
    .drain_start (drain_start),
    .psum_valid  (psum_valid),
    .psum        (psum),
    .quant_valid (quant_valid),
    .quant       (quant),
    .drain_done  (drain_done)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic stim_t make_load(input int mode, input int start, input int size);
    stim_t st;
    st = '0;
    st.mode = mode[0];
    st.start = start[7:0];
    st.size = size[7:0];
    return st;
  endfunction

  function automatic stim_t make_drain(input int kind, input int restart);
    stim_t st;
    st = '0;
    st.is_drain = 1'b1;
    st.psum_kind = kind[1:0];
    st.restart_at = restart[4:0];
    return st;
  endfunction

  // multiply, add half, floor divide, clamp to int8
  function automatic int expect_q(input int p, input int s);
    int div;
    int num;
    int q;
    div = 1 << requant_shift;
    num = p * s + div / 2;
    if (num >= 0) begin
      q = num / div;
    end else begin
      q = -((-num + div - 1) / div);
    end
    if (q > 127) begin
      q = 127;
    end else if (q < -128) begin
      q = -128;
    end
    return q;
  endfunction

  // small sums land mostly inside int8, extremes hit both rails
  function automatic logic signed [psum_width-1:0] gen_psum(
    input int kind,
    input int k,
    input int lane
  );
    int v;
    if (kind == 0) begin
      v = $random(seed) % 41;
    end else if (k <= 2) begin
      // lanes take opposite ends, swapped between k 1 and 2
      v = ((k == 1) != (lane == 1)) ? (1 << 19) - 1 : -(1 << 19);
    end else begin
      v = $random(seed);
    end
    return v[psum_width-1:0];
  endfunction

  task automatic check_value(
    input string what,
    input int row,
    input int idx,
    input int got,
    input int expected
  );
    assert (got == expected) else begin
      $display("CHECK FAILED at %0t: %s row %0d index %0d got %0d expected %0d",
               $time, what, row, idx, got, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // scale load with model update
  ////////////////////////////////////////////////////////////

  task automatic apply_load(input stim_t st);
    logic [511:0] word;
    int start;
    int size;
    int base;
    for (int i = 0; i < 16; i++) begin
      word[32*i +: 32] = $random(seed);
    end
    start = int'(st.start);
    size = int'(st.size);
    scale_load = 1'b1;
    scale_cfg.mode = st.mode;
    scale_cfg.start = st.start;
    scale_cfg.size = st.size;
    scale_word = scale_word_u'(word);
    @(negedge clk);
    scale_load = 1'b0;
    for (int s = 1; s <= 64; s++) begin
      if (s >= start && s <= start + size - 1) begin
        if (!st.mode) begin
          // byte s-1 into lane 0
          model_lo[s] = word[8*(s-1) +: 8];
          model_hi[s] = 8'd0;
        end else if ((start == 1 && s <= 32) || (start == 33 && s >= 33)) begin
          base = 16 * (s - start);
          model_lo[s] = word[base +: 8];
          model_hi[s] = word[base+8 +: 8];
        end else begin
          // other mode 1 starts clear the range
          model_lo[s] = 8'd0;
          model_hi[s] = 8'd0;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // drain, playing the skewed array
  ////////////////////////////////////////////////////////////

  task automatic run_drain(input stim_t st);
    int k;
    int s;
    int exp_idx;
    for (int r = 0; r < 4; r++) begin
      for (int j = 1; j <= 16; j++) begin
        p_lo[r][j] = gen_psum(int'(st.psum_kind), j, 0);
        p_hi[r][j] = gen_psum(int'(st.psum_kind), j, 1);
      end
    end
    drain_start = 1'b1;
    @(negedge clk);
    for (int c = 1; c <= drain_cycles; c++) begin
      // only this one extra pulse, while busy
      drain_start = (st.restart_at != 0) && (c == int'(st.restart_at));
      // index k on the counter during cycle k
      exp_idx = (c <= 16) ? c : 0;
      check_value("row index", 0, c, int'(requant_top_i.next_row_idx), exp_idx);
      check_value("drain_done", 0, c, int'(drain_done), int'(c == 16));
      for (int r = 0; r < 4; r++) begin
        // result for index k shows one cycle after its psum
        k = c - r - 2;
        check_value("quant_valid", r + 1, k, int'(quant_valid[r]), int'(k >= 1 && k <= 16));
        if (k >= 1 && k <= 16) begin
          s = r * 16 + k;
          check_value("q_lo", r + 1, k, int'(quant[r].q_lo),
                      expect_q(int'(p_lo[r][k]), int'(model_lo[s])));
          check_value("q_hi", r + 1, k, int'(quant[r].q_hi),
                      expect_q(int'(p_hi[r][k]), int'(model_hi[s])));
        end else if (k > 16) begin
          // valid low, last result of the row stays
          s = r * 16 + 16;
          check_value("q_lo hold", r + 1, k, int'(quant[r].q_lo),
                      expect_q(int'(p_lo[r][16]), int'(model_lo[s])));
          check_value("q_hi hold", r + 1, k, int'(quant[r].q_hi),
                      expect_q(int'(p_hi[r][16]), int'(model_hi[s])));
        end
        // psum for index k sits under the posedge that shows its scale
        k = c - r - 1;
        if (k >= 1 && k <= 16) begin
          psum_valid[r] = 1'b1;
          psum[r].psum_lo = p_lo[r][k];
          psum[r].psum_hi = p_hi[r][k];
        end else begin
          psum_valid[r] = 1'b0;
          psum[r] = '0;
        end
      end
      @(negedge clk);
    end
    drain_start = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    scale_load = 1'b0;
    scale_cfg = '0;
    scale_word = '0;
    drain_start = 1'b0;
    psum_valid = '0;
    for (int r = 0; r < 4; r++) begin
      psum[r] = '0;
    end
    for (int s = 0; s <= 64; s++) begin
      model_lo[s] = 8'd0;
      model_hi[s] = 8'd0;
    end

    // empty bank, full load, two halves, patch, extremes, cleared range
    stim_table[0] = make_drain(0, 0);
    stim_table[1] = make_load(0, 1, 64);
    stim_table[2] = make_drain(0, 5);
    stim_table[3] = make_load(1, 1, 32);
    stim_table[4] = make_load(1, 33, 32);
    stim_table[5] = make_drain(0, 0);
    stim_table[6] = make_load(0, 20, 5);
    stim_table[7] = make_drain(1, 0);
    stim_table[8] = make_load(1, 5, 3);
    stim_table[9] = make_drain(0, 12);

    repeat (16) @(negedge clk);
    reset = 1'b0;

    // quiet outputs after reset
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      check_value("quant_valid idle", 0, c, int'(quant_valid), 0);
      check_value("drain_done idle", 0, c, int'(drain_done), 0);
      for (int r = 0; r < 4; r++) begin
        check_value("quant idle", r + 1, c, int'(quant[r]), 0);
      end
    end

    for (int n = 0; n < num_steps; n++) begin
      if (stim_table[n].is_drain) begin
        run_drain(stim_table[n]);
      end else begin
        apply_load(stim_table[n]);
      end
    end

    repeat (2) @(negedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/requant_top.sv
`timescale 1ns/1ns
`default_nettype none

module requant_top (
  input  logic                                clk,
  input  logic                                reset,
  // scale load port
  input  logic                                scale_load,
  input  quant_pkg::scale_load_t              scale_cfg,
  input  quant_pkg::scale_word_u              scale_word,
  // drain and skewed partial sums
  input  logic                                drain_start,
  input  logic [quant_pkg::sa_row_num-1:0]    psum_valid,
  input  quant_pkg::row_psum_t                psum [quant_pkg::sa_row_num],
  // int8 results per sa row
  output logic [quant_pkg::sa_row_num-1:0]    quant_valid,
  output quant_pkg::row_quant_t               quant [quant_pkg::sa_row_num],
  output logic                                drain_done
);

  import quant_pkg::*;

  // row index, 0 when idle
  row_idx_t next_row_idx;
  // staircased sets, row r delayed by r+1
  scale_set_t row_scale [sa_row_num];

  ////////////////////////////////////////////////////////////
  // index producer
  ////////////////////////////////////////////////////////////

  out_row_sequencer out_row_sequencer_i (
    .clk          (clk),
    .reset        (reset),
    .drain_start  (drain_start),
    .next_row_idx (next_row_idx),
    .drain_done   (drain_done)
  );

  ////////////////////////////////////////////////////////////
  // scale storage and skew
  ////////////////////////////////////////////////////////////

  scale_bank scale_bank_i (
    .clk          (clk),
    .reset        (reset),
    .scale_load   (scale_load),
    .scale_cfg    (scale_cfg),
    .scale_word   (scale_word),
    .next_row_idx (next_row_idx),
    .row_scale    (row_scale)
  );

  ////////////////////////////////////////////////////////////
  // requant lanes
  ////////////////////////////////////////////////////////////

  // psum arrives already skewed from the array
  for (genvar r = 0; r < sa_row_num; r++) begin : g_lane
    requant_lane requant_lane_i (
      .clk         (clk),
      .reset       (reset),
      .psum_valid  (psum_valid[r]),
      .psum        (psum[r]),
      .row_scale   (row_scale[r]),
      .quant_valid (quant_valid[r]),
      .quant       (quant[r])
    );
  end

endmodule

`default_nettype wire

//--- source/requant_lane.sv
`timescale 1ns/1ns
`default_nettype none

module requant_lane (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psum_valid,
  input  quant_pkg::row_psum_t  psum,
  input  quant_pkg::scale_set_t row_scale,
  output logic                  quant_valid,
  output quant_pkg::row_quant_t quant
);

  import quant_pkg::*;

  ////////////////////////////////////////////////////////////
  // requant math
  ////////////////////////////////////////////////////////////

  // psum * scale, round half up, arith shift, clamp to int8
  function automatic logic signed [q_width-1:0] requant(
    input logic signed [psum_width-1:0] p,
    input logic [scale_width-1:0]       s
  );
    logic signed [prod_width-1:0] prod;
    logic signed [prod_width-1:0] shifted;
    logic signed [q_width-1:0]    q;
    // scale is unsigned, so one zero bit keeps it positive
    prod = p * $signed({1'b0, s});
    // round before the shift, floor on negatives
    shifted = prod_width'((prod + round_half) >>> requant_shift);
    if (shifted > q_max) begin
      q = q_width'(q_max);
    end else if (shifted < q_min) begin
      q = q_width'(q_min);
    end else begin
      q = shifted[q_width-1:0];
    end
    return q;
  endfunction

  row_quant_t quant_next;

  // same arithmetic for both weight lanes
  assign quant_next.q_lo = requant(psum.psum_lo, row_scale.scale_lo);
  assign quant_next.q_hi = requant(psum.psum_hi, row_scale.scale_hi);

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  // one cycle behind psum_valid
  always_ff @(posedge clk) begin
    if (reset) begin
      quant_valid <= 1'b0;
    end else begin
      quant_valid <= psum_valid;
    end
  end

  // holds last result while valid is low
  always_ff @(posedge clk) begin
    if (reset) begin
      quant <= '0;
    end else if (psum_valid) begin
      quant <= quant_next;
    end
  end

endmodule

`default_nettype wire

//--- source/scale_bank.sv
`timescale 1ns/1ns
`default_nettype none

module scale_bank (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   scale_load,
  input  quant_pkg::scale_load_t scale_cfg,
  input  quant_pkg::scale_word_u scale_word,
  input  quant_pkg::row_idx_t    next_row_idx,
  output quant_pkg::scale_set_t  row_scale [quant_pkg::sa_row_num]
);

  import quant_pkg::*;

  // set s lives at tile[s-1]
  scale_set_t tile [scale_sets_num];

  // per-set write strobe and data
  logic [scale_sets_num-1:0] wr_mask;
  scale_set_t wr_set [scale_sets_num];

  // mode 1 only knows the two halves
  logic start_lo;
  logic start_hi;

  // offset of the index inside one sa row
  logic [row_off_width-1:0] row_off;

  ////////////////////////////////////////////////////////////
  // load decode
  ////////////////////////////////////////////////////////////

  assign start_lo = (scale_cfg.start == 8'd1);
  assign start_hi = (scale_cfg.start == 8'(sets_per_word + 1));

  always_comb begin
    for (int i = 0; i < scale_sets_num; i++) begin
      // range check in int, start+size may pass 255
      wr_mask[i] = (i + 1 >= int'(scale_cfg.start)) &&
                   (i + 1 < int'(scale_cfg.start) + int'(scale_cfg.size));
      if (!scale_cfg.mode) begin
        // byte i zero-extended into lane 0
        wr_set[i].scale_hi = '0;
        wr_set[i].scale_lo = scale_word.as_bytes[i];
      end else if (start_lo && (i < sets_per_word)) begin
        wr_set[i] = scale_word.as_sets[i % sets_per_word];
      end else if (start_hi && (i >= sets_per_word)) begin
        wr_set[i] = scale_word.as_sets[i % sets_per_word];
      end else begin
        // any other mode 1 start clears its range
        wr_set[i] = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // scale storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < scale_sets_num; i++) begin
        tile[i] <= '0;
      end
    end else if (scale_load) begin
      for (int i = 0; i < scale_sets_num; i++) begin
        if (wr_mask[i]) begin
          tile[i] <= wr_set[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // skewed read out
  ////////////////////////////////////////////////////////////

  // index k maps to offset k-1 in every sa row
  assign row_off = row_off_width'(next_row_idx - row_idx_t'(1));

  for (genvar r = 0; r < sa_row_num; r++) begin : g_row
    // stage d holds the set d+1 cycles after the index
    scale_set_t rd_set;
    scale_set_t stair [r + 1];

    // idle index reads as an all-zero set
    assign rd_set = (next_row_idx != '0) ? tile[r * row_num_in_sa + int'(row_off)] : '0;

    // row r+1 sees its set r+1 cycles late, like the array diagonal
    always_ff @(posedge clk) begin
      if (reset) begin
        for (int d = 0; d <= r; d++) begin
          stair[d] <= '0;
        end
      end else begin
        stair[0] <= rd_set;
        for (int d = 1; d <= r; d++) begin
          stair[d] <= stair[d-1];
        end
      end
    end

    assign row_scale[r] = stair[r];
  end

endmodule

`default_nettype wire

//--- source/out_row_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module out_row_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                drain_start,
  output quant_pkg::row_idx_t next_row_idx,
  output logic                drain_done
);

  import quant_pkg::*;

  ////////////////////////////////////////////////////////////
  // drain control
  ////////////////////////////////////////////////////////////

  // high from the first index through the last one
  logic busy;
  logic last_idx;
  logic next_is_last;

  // index 16 on the counter now
  assign last_idx = (next_row_idx == row_idx_t'(row_num_in_sa));
  // index 15 now, so 16 comes next cycle
  assign next_is_last = (next_row_idx == row_idx_t'(row_num_in_sa - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (!busy && drain_start) begin
      busy <= 1'b1;
    end else if (busy && last_idx) begin
      busy <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // row index counter
  ////////////////////////////////////////////////////////////

  // starts at 1 the cycle after the pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      next_row_idx <= '0;
    end else if (!busy && drain_start) begin
      next_row_idx <= row_idx_t'(1);
    end else if (busy) begin
      if (last_idx) begin
        // back to idle index
        next_row_idx <= '0;
      end else begin
        next_row_idx <= next_row_idx + row_idx_t'(1);
      end
    end
  end

  // a start while busy falls through to the step branch

  // done lines up with index 16
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_done <= 1'b0;
    end else begin
      drain_done <= busy && next_is_last;
    end
  end

endmodule

`default_nettype wire

//--- source/quant_pkg.sv
`default_nettype none

package quant_pkg;

  ////////////////////////////////////////////////////////////
  // array geometry
  ////////////////////////////////////////////////////////////

  // rows of the conv core
  localparam int sa_row_num = 4;
  // output rows inside one sa row
  localparam int row_num_in_sa = 16;
  localparam int row_off_width = $clog2(row_num_in_sa);

  ////////////////////////////////////////////////////////////
  // scale storage
  ////////////////////////////////////////////////////////////

  // one scale, unsigned
  localparam int scale_width = 8;
  // two lanes per set
  localparam int scale_set_width = 2 * scale_width;
  localparam int scale_sets_num = sa_row_num * row_num_in_sa;
  localparam int scale_word_width = 512;
  // mode 0 slices, 64
  localparam int bytes_per_word = scale_word_width / scale_width;
  // mode 1 slices, 32
  localparam int sets_per_word = scale_word_width / scale_set_width;

  ////////////////////////////////////////////////////////////
  // requant arithmetic
  ////////////////////////////////////////////////////////////

  localparam int psum_width = 20;
  localparam int requant_shift = 6;
  localparam int round_half = 1 << (requant_shift - 1);
  // signed psum times zero-extended scale
  localparam int prod_width = psum_width + scale_width + 1;
  localparam int q_width = 8;
  localparam int q_max = 127;
  localparam int q_min = -128;

  // lane 0 in the low byte
  typedef struct packed {
    logic [scale_width-1:0] scale_hi;
    logic [scale_width-1:0] scale_lo;
  } scale_set_t;

  // one load word, two readings
  typedef union packed {
    logic [bytes_per_word-1:0][scale_width-1:0] as_bytes;
    scale_set_t [sets_per_word-1:0]             as_sets;
  } scale_word_u;

  typedef struct packed {
    logic       mode;
    logic [7:0] start;
    logic [7:0] size;
  } scale_load_t;

  typedef struct packed {
    logic signed [psum_width-1:0] psum_hi;
    logic signed [psum_width-1:0] psum_lo;
  } row_psum_t;

  typedef struct packed {
    logic signed [q_width-1:0] q_hi;
    logic signed [q_width-1:0] q_lo;
  } row_quant_t;

  // 0 means idle, 1..16 a live row
  typedef logic [4:0] row_idx_t;

endpackage

`default_nettype wire
